/* logic/dcache_pkg.sv */
package dcache_pkg;

    // byte address and block geometry
    localparam int ADDR_BITS   = 32;
    localparam int BLOCK_BITS  = 64;
    localparam int OFFSET_BITS = 3;

    // fully associative, so the whole upper address is the tag
    localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS;

    localparam int MEM_TAG_BITS = 4;

    // reset value of the eviction LFSR, must stay nonzero after truncation
    localparam logic [7:0] LFSR_SEED = 8'hb5;

    typedef logic [BLOCK_BITS-1:0] mem_block_t;

    // zero means no transaction
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

    // one address word, seen whole on the memory side or split for lookup
    typedef union packed {
        logic [ADDR_BITS-1:0] raw;
        struct packed {
            logic [TAG_BITS-1:0]    tag;
            logic [OFFSET_BITS-1:0] offset;
        } fields;
    } dcache_addr_t;

    // one load port request
    typedef struct packed {
        logic         valid;
        dcache_addr_t addr;
    } addr_packet_t;

    // one load port result
    typedef struct packed {
        logic       valid;
        mem_block_t data;
    } cache_data_t;

endpackage

/* logic/cache_mshr_if.sv */
`timescale 1ns/1ps

interface cache_mshr_if #(
    parameter int N = 2
);
    import dcache_pkg::*;

    // miss strobes, same cycle as the load
    logic [N-1:0]               miss_valid;
    logic [N-1:0][TAG_BITS-1:0] miss_tag;

    // one line write per strobe
    logic                       fill_valid;
    logic [TAG_BITS-1:0]        fill_tag;
    mem_block_t                 fill_data;

    modport cache (
        output miss_valid, miss_tag,
        input  fill_valid, fill_tag, fill_data
    );

    modport mshr (
        input  miss_valid, miss_tag,
        output fill_valid, fill_tag, fill_data
    );

endinterface

/* logic/lfsr.sv */
`timescale 1ns/1ps

module lfsr #(
    parameter int BITS = 4
) (
    input  logic            clock,
    input  logic            rst,
    input  logic [BITS-1:0] seed,
    output logic [BITS-1:0] value
);

    // maximal-length Galois feedback masks, shift right form
    function automatic logic [BITS-1:0] taps_for(input int width);
        logic [7:0] mask;
        case (width)
            2:       mask = 8'h03;
            3:       mask = 8'h06;
            4:       mask = 8'h0c;
            5:       mask = 8'h14;
            6:       mask = 8'h30;
            7:       mask = 8'h60;
            default: mask = 8'hb8;
        endcase
        return mask[BITS-1:0];
    endfunction

    localparam logic [BITS-1:0] TAPS = taps_for(BITS);

    always_ff @(posedge clock) begin
        if (rst) begin
            value <= seed;
        end else if (value[0]) begin
            value <= (value >> 1) ^ TAPS;
        end else begin
            value <= value >> 1;
        end
    end

endmodule

/* logic/dcache.sv */
`timescale 1ns/1ps

module dcache #(
    parameter int N     = 2,
    parameter int LINES = 8
) (
    input  logic                               clock,
    input  logic                               rst,
    input  dcache_pkg::addr_packet_t [N-1:0]   read_addr,
    output dcache_pkg::cache_data_t  [N-1:0]   cache_out,
    cache_mshr_if.cache                        mshr
);
    import dcache_pkg::*;

    localparam int IDX_BITS = $clog2(LINES);
    // one extra bit so the low bits also reach index zero
    localparam int LFSR_BITS = IDX_BITS + 1;

    logic [LINES-1:0]                line_valid;
    logic [LINES-1:0][TAG_BITS-1:0]  line_tag;
    mem_block_t [LINES-1:0]          line_data;

    logic [N-1:0][LINES-1:0]         hit_onehot;

    logic [LFSR_BITS-1:0]            lfsr_value;
    logic [IDX_BITS-1:0]             evict_idx;
    logic [LINES-1:0]                free_onehot;
    logic [LINES-1:0]                evict_onehot;
    logic [LINES-1:0]                fill_onehot;

    // tag compare, every port against every line
    for (genvar p = 0; p < N; p++) begin : g_port
        for (genvar l = 0; l < LINES; l++) begin : g_line
            assign hit_onehot[p][l] = read_addr[p].valid && line_valid[l] &&
                                      (line_tag[l] == read_addr[p].addr.fields.tag);
        end
    end

    // at most one line matches, so the data can be OR-ed together
    always_comb begin
        for (int p = 0; p < N; p++) begin
            cache_out[p] = '0;
            for (int l = 0; l < LINES; l++) begin
                if (hit_onehot[p][l]) begin
                    cache_out[p].valid = 1'b1;
                    cache_out[p].data  = cache_out[p].data | line_data[l];
                end
            end
            mshr.miss_valid[p] = read_addr[p].valid && !cache_out[p].valid;
            mshr.miss_tag[p]   = read_addr[p].addr.fields.tag;
        end
    end

    lfsr #(
        .BITS (LFSR_BITS)
    ) i_lfsr (
        .clock (clock),
        .rst   (rst),
        .seed  (LFSR_BITS'(LFSR_SEED)),
        .value (lfsr_value)
    );

    assign evict_idx = lfsr_value[IDX_BITS-1:0];

    // lowest clear bit of line_valid
    assign free_onehot  = ~line_valid & (line_valid + 1'b1);
    assign evict_onehot = LINES'(1) << evict_idx;

    // random victim only once the array is full
    assign fill_onehot = (|free_onehot) ? free_onehot : evict_onehot;

    always_ff @(posedge clock) begin
        if (rst) begin
            line_valid <= '0;
        end else if (mshr.fill_valid) begin
            line_valid <= line_valid | fill_onehot;
        end
    end

    always_ff @(posedge clock) begin
        if (mshr.fill_valid) begin
            for (int l = 0; l < LINES; l++) begin
                if (fill_onehot[l]) begin
                    line_tag[l]  <= mshr.fill_tag;
                    line_data[l] <= mshr.fill_data;
                end
            end
        end
    end

endmodule

/* logic/dcache_mshr.sv */
`timescale 1ns/1ps

module dcache_mshr #(
    parameter int N            = 2,
    parameter int MSHR_ENTRIES = 4
) (
    input  logic                              clock,
    input  logic                              rst,
    cache_mshr_if.mshr                        cache,
    output logic                              mem_req_valid,
    output logic [dcache_pkg::ADDR_BITS-1:0]  mem_req_addr,
    input  logic                              mem_req_accepted,
    input  dcache_pkg::mem_tag_t              current_req_tag,
    input  dcache_pkg::mem_block_t            mem_data,
    input  dcache_pkg::mem_tag_t              mem_data_tag
);
    import dcache_pkg::*;

    localparam int IDX_BITS = (MSHR_ENTRIES > 1) ? $clog2(MSHR_ENTRIES) : 1;

    localparam logic [1:0] ST_FREE   = 2'd0;
    localparam logic [1:0] ST_WAIT   = 2'd1;
    localparam logic [1:0] ST_ISSUED = 2'd2;

    logic [MSHR_ENTRIES-1:0][1:0]              ent_state;
    logic [MSHR_ENTRIES-1:0][TAG_BITS-1:0]     ent_tag;
    mem_tag_t [MSHR_ENTRIES-1:0]               ent_mem_tag;
    // allocation age, [i][j] set when entry i came before entry j
    logic [MSHR_ENTRIES-1:0][MSHR_ENTRIES-1:0] older_than;

    logic [MSHR_ENTRIES-1:0]                   busy;
    logic [MSHR_ENTRIES-1:0]                   waiting;
    logic [MSHR_ENTRIES-1:0]                   alloc_en;
    logic [MSHR_ENTRIES-1:0][TAG_BITS-1:0]     tag_next;
    logic [MSHR_ENTRIES-1:0][MSHR_ENTRIES-1:0] older_next;
    logic [MSHR_ENTRIES-1:0][MSHR_ENTRIES-1:0] older_col;
    logic [MSHR_ENTRIES-1:0]                   oldest;

    logic                                      issue_valid;
    logic [IDX_BITS-1:0]                       issue_idx;
    dcache_addr_t                              req_addr;
    logic                                      resp_hit;
    logic [IDX_BITS-1:0]                       resp_idx;

    for (genvar i = 0; i < MSHR_ENTRIES; i++) begin : g_entry
        assign busy[i]    = (ent_state[i] != ST_FREE);
        assign waiting[i] = (ent_state[i] == ST_WAIT);
        for (genvar j = 0; j < MSHR_ENTRIES; j++) begin : g_col
            assign older_col[i][j] = older_than[j][i];
        end
        // no other waiting entry was allocated earlier
        assign oldest[i] = waiting[i] && !(|(waiting & older_col[i]));
    end

    // merge against busy entries, the pending fill and lower ports,
    // then hand out free entries lowest port first
    always_comb begin
        logic [MSHR_ENTRIES-1:0] avail;
        logic                    dup;
        logic                    placed;
        alloc_en   = '0;
        tag_next   = ent_tag;
        older_next = older_than;
        avail      = ~busy;
        for (int p = 0; p < N; p++) begin
            dup = cache.fill_valid && (cache.fill_tag == cache.miss_tag[p]);
            for (int e = 0; e < MSHR_ENTRIES; e++) begin
                if (busy[e] && (ent_tag[e] == cache.miss_tag[p])) begin
                    dup = 1'b1;
                end
            end
            for (int q = 0; q < p; q++) begin
                if (cache.miss_valid[q] && (cache.miss_tag[q] == cache.miss_tag[p])) begin
                    dup = 1'b1;
                end
            end
            placed = 1'b0;
            if (cache.miss_valid[p] && !dup) begin
                for (int e = 0; e < MSHR_ENTRIES; e++) begin
                    if (avail[e] && !placed) begin
                        placed      = 1'b1;
                        avail[e]    = 1'b0;
                        alloc_en[e] = 1'b1;
                        tag_next[e] = cache.miss_tag[p];
                        for (int j = 0; j < MSHR_ENTRIES; j++) begin
                            older_next[e][j] = 1'b0;
                            older_next[j][e] = !avail[j] && (j != e);
                        end
                    end
                end
            end
        end
    end

    // oldest waiting entry goes to memory
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        resp_hit    = 1'b0;
        resp_idx    = '0;
        for (int e = 0; e < MSHR_ENTRIES; e++) begin
            if (oldest[e]) begin
                issue_valid = 1'b1;
                issue_idx   = IDX_BITS'(e);
            end
            if ((mem_data_tag != '0) && (ent_state[e] == ST_ISSUED) &&
                (ent_mem_tag[e] == mem_data_tag)) begin
                resp_hit = 1'b1;
                resp_idx = IDX_BITS'(e);
            end
        end
        req_addr.fields.tag    = ent_tag[issue_idx];
        req_addr.fields.offset = '0;
    end

    assign mem_req_valid = issue_valid;
    assign mem_req_addr  = req_addr.raw;

    always_ff @(posedge clock) begin
        if (rst) begin
            ent_state        <= '0;
            older_than       <= '0;
            cache.fill_valid <= 1'b0;
        end else begin
            older_than       <= older_next;
            cache.fill_valid <= resp_hit;
            for (int e = 0; e < MSHR_ENTRIES; e++) begin
                if (alloc_en[e]) begin
                    ent_state[e] <= ST_WAIT;
                end else if (issue_valid && mem_req_accepted && (issue_idx == e)) begin
                    ent_state[e] <= ST_ISSUED;
                end else if (resp_hit && (resp_idx == e)) begin
                    ent_state[e] <= ST_FREE;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        ent_tag <= tag_next;
        if (issue_valid && mem_req_accepted) begin
            ent_mem_tag[issue_idx] <= current_req_tag;
        end
        if (resp_hit) begin
            cache.fill_tag  <= ent_tag[resp_idx];
            cache.fill_data <= mem_data;
        end
    end

endmodule

/* logic/dcache_subsystem.sv */
`timescale 1ns/1ps

module dcache_subsystem #(
    parameter int N            = 2,
    parameter int LINES        = 8,
    parameter int MSHR_ENTRIES = 4
) (
    input  logic                              clock,
    input  logic                              rst,

    // load ports
    input  dcache_pkg::addr_packet_t [N-1:0]  read_addr,
    output dcache_pkg::cache_data_t  [N-1:0]  cache_out,

    // memory request side, held until accepted
    output logic                              mem_req_valid,
    output logic [dcache_pkg::ADDR_BITS-1:0]  mem_req_addr,
    input  logic                              mem_req_accepted,
    input  dcache_pkg::mem_tag_t              current_req_tag,

    // memory response, any order
    input  dcache_pkg::mem_block_t            mem_data,
    input  dcache_pkg::mem_tag_t              mem_data_tag
);

    // misses out of the cache, fills back in
    cache_mshr_if #(
        .N (N)
    ) miss_fill ();

    dcache #(
        .N     (N),
        .LINES (LINES)
    ) i_dcache (
        .clock     (clock),
        .rst       (rst),
        .read_addr (read_addr),
        .cache_out (cache_out),
        .mshr      (miss_fill.cache)
    );

    dcache_mshr #(
        .N            (N),
        .MSHR_ENTRIES (MSHR_ENTRIES)
    ) i_dcache_mshr (
        .clock            (clock),
        .rst              (rst),
        .cache            (miss_fill.mshr),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_accepted (mem_req_accepted),
        .current_req_tag  (current_req_tag),
        .mem_data         (mem_data),
        .mem_data_tag     (mem_data_tag)
    );

endmodule

/* verification/mem_responder.sv */
`timescale 1ns/1ps

module mem_responder #(
    parameter logic [63:0] DATA_MIX = 64'h9e37_79b9_7f4a_7c15
) (
    input  logic                                   clock,
    input  logic                                   rst,
    input  int                                     stall_cycles,
    input  logic                                   mem_req_valid,
    input  logic [dcache_pkg::ADDR_BITS-1:0]       mem_req_addr,
    output logic                                   mem_req_accepted,
    output dcache_pkg::mem_tag_t                   current_req_tag,
    input  dcache_pkg::mem_tag_t                   resp_tag,
    output dcache_pkg::mem_block_t                 mem_data,
    output dcache_pkg::mem_tag_t                   mem_data_tag,
    output logic [15:0]                            tag_live,
    output logic [15:0][dcache_pkg::ADDR_BITS-1:0] tag_addr,
    output int                                     accept_count
);
    import dcache_pkg::*;

    int wait_count;

    // block contents are the block address mixed with a constant
    function automatic mem_block_t model_block(logic [ADDR_BITS-1:0] addr);
        return {addr, ~addr} ^ DATA_MIX;
    endfunction

    // accept once the request has waited stall_cycles
    assign mem_req_accepted = mem_req_valid && (wait_count >= stall_cycles);
    assign mem_data_tag     = resp_tag;
    assign mem_data         = model_block(tag_addr[resp_tag]);

    always_ff @(posedge clock) begin
        if (rst) begin
            current_req_tag <= 4'd1;
            wait_count      <= 0;
            accept_count    <= 0;
            tag_live        <= '0;
        end else begin
            if (mem_req_accepted) begin
                tag_addr[current_req_tag] <= mem_req_addr;
                tag_live[current_req_tag] <= 1'b1;
                // zero is reserved, wrap back to one
                current_req_tag <= (current_req_tag == 4'hf) ? 4'd1 : current_req_tag + 4'd1;
                wait_count      <= 0;
                accept_count    <= accept_count + 1;
            end else if (mem_req_valid) begin
                wait_count <= wait_count + 1;
            end
            if (resp_tag != '0) begin
                tag_live[resp_tag] <= 1'b0;
            end
        end
    end

endmodule

/* verification/dcache_subsystem_tb.sv */
`timescale 1ns/1ps

module dcache_subsystem_tb;
    import dcache_pkg::*;

    localparam int N            = 2;
    localparam int LINES        = 8;
    localparam int MSHR_ENTRIES = 4;
    localparam int HIT_LIMIT    = 40;
    // each test stays well inside this many cycles
    localparam int TEST_CYCLES  = 300;
    localparam int WATCHDOG_NS  = (6 * TEST_CYCLES + 20) * 10;
    localparam logic [63:0] DATA_MIX = 64'h9e37_79b9_7f4a_7c15;

    logic                        clock;
    logic                        rst;
    addr_packet_t [N-1:0]        read_addr;
    cache_data_t  [N-1:0]        cache_out;
    logic                        mem_req_valid;
    logic [ADDR_BITS-1:0]        mem_req_addr;
    logic                        mem_req_accepted;
    mem_tag_t                    current_req_tag;
    mem_block_t                  mem_data;
    mem_tag_t                    mem_data_tag;
    int                          stall_cycles;
    mem_tag_t                    resp_tag;
    logic [15:0]                 tag_live;
    logic [15:0][ADDR_BITS-1:0]  tag_addr;
    int                          accept_count;
    int                          seed;
    int                          error_count;
    logic [ADDR_BITS-1:0]        blocks [9];

    dcache_subsystem #(
        .N            (N),
        .LINES        (LINES),
        .MSHR_ENTRIES (MSHR_ENTRIES)
    ) i_dcache_subsystem (
        .clock            (clock),
        .rst              (rst),
        .read_addr        (read_addr),
        .cache_out        (cache_out),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_accepted (mem_req_accepted),
        .current_req_tag  (current_req_tag),
        .mem_data         (mem_data),
        .mem_data_tag     (mem_data_tag)
    );

    mem_responder #(
        .DATA_MIX (DATA_MIX)
    ) i_mem_responder (
        .clock            (clock),
        .rst              (rst),
        .stall_cycles     (stall_cycles),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_accepted (mem_req_accepted),
        .current_req_tag  (current_req_tag),
        .resp_tag         (resp_tag),
        .mem_data         (mem_data),
        .mem_data_tag     (mem_data_tag),
        .tag_live         (tag_live),
        .tag_addr         (tag_addr),
        .accept_count     (accept_count)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic drive_load(int port, logic [ADDR_BITS-1:0] addr);
        read_addr[port].valid    = 1'b1;
        read_addr[port].addr.raw = addr;
    endtask

    function automatic logic [ADDR_BITS-1:0] block_of(logic [ADDR_BITS-1:0] addr);
        return {addr[ADDR_BITS-1:OFFSET_BITS], OFFSET_BITS'(0)};
    endfunction

    // block data is its address mixed with a constant
    function automatic mem_block_t expected_block(logic [ADDR_BITS-1:0] addr);
        return {block_of(addr), ~block_of(addr)} ^ DATA_MIX;
    endfunction

    task automatic report_failure(string what);
        error_count++;
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        assert (expected === actual) else begin
            error_count++;
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic apply_reset();
        rst          = 1'b1;
        read_addr    = '0;
        resp_tag     = '0;
        stall_cycles = 0;
        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;
    endtask

    task automatic pick_blocks(int count);
        for (int k = 0; k < count; k++) begin
            blocks[k] = block_of($random(seed));
        end
    endtask

    // live memory tag of a block or zero
    function automatic mem_tag_t tag_of(logic [ADDR_BITS-1:0] block);
        mem_tag_t tag;
        tag = '0;
        for (int t = 1; t < 16; t++) begin
            if (tag_live[t] && (tag_addr[t] == block)) begin
                tag = mem_tag_t'(t);
            end
        end
        return tag;
    endfunction

    // answer any live request for the block until the load hits
    task automatic serve_until_hit(string name, int port, logic [ADDR_BITS-1:0] addr);
        int cycles;
        cycles   = 0;
        resp_tag = tag_of(block_of(addr));
        #1;
        while (!cache_out[port].valid) begin
            cycles++;
            assert (cycles < HIT_LIMIT) else report_failure({name, ": load never hit"});
            step();
            resp_tag = tag_of(block_of(addr));
            #1;
        end
        check_value({name, " data"}, expected_block(addr), cache_out[port].data);
    endtask

    task automatic check_hit(string name, int port, logic [ADDR_BITS-1:0] addr);
        drive_load(port, addr);
        #1;
        check_value({name, " valid"}, 1, cache_out[port].valid);
        check_value({name, " data"}, expected_block(addr), cache_out[port].data);
    endtask

    task automatic test_reset_state();
        apply_reset();
        repeat (4) begin
            check_value("reset_state mem_req_valid", 0, mem_req_valid);
            step();
        end
        pick_blocks(2);
        drive_load(0, blocks[0] + 3);
        drive_load(1, blocks[1]);
        #1;
        check_value("reset_state port0 valid", 0, cache_out[0].valid);
        check_value("reset_state port1 valid", 0, cache_out[1].valid);
    endtask

    task automatic test_miss_then_hit();
        apply_reset();
        pick_blocks(1);
        drive_load(0, blocks[0] + 5);
        serve_until_hit("miss_then_hit", 0, blocks[0] + 5);
        // first tag after reset is one
        check_value("miss_then_hit request address", blocks[0], tag_addr[1]);
        step();
        check_hit("miss_then_hit port0 offset 0", 0, blocks[0]);
        check_hit("miss_then_hit port1 offset 7", 1, blocks[0] + 7);
        check_value("miss_then_hit requests", 1, accept_count);
    endtask

    task automatic test_merge();
        apply_reset();
        pick_blocks(1);
        drive_load(0, blocks[0] + 6);
        drive_load(1, blocks[0] + 2);
        serve_until_hit("merge", 0, blocks[0] + 6);
        check_value("merge requests", 1, accept_count);
        check_value("merge port1 valid", 1, cache_out[1].valid);
    endtask

    task automatic test_stall_reorder();
        logic [ADDR_BITS-1:0] held;
        logic                 held_valid;
        int                   cycles;
        apply_reset();
        pick_blocks(3);
        stall_cycles = 3;
        drive_load(0, blocks[0]);
        drive_load(1, blocks[1]);
        step();
        drive_load(0, blocks[2]);
        read_addr[1].valid = 1'b0;
        held_valid = 1'b0;
        held       = '0;
        cycles     = 0;
        #1;
        while (accept_count < 3) begin
            if (held_valid) begin
                check_value("stall_reorder held valid", 1, mem_req_valid);
                check_value("stall_reorder held address", held, mem_req_addr);
            end
            held_valid = mem_req_valid && !mem_req_accepted;
            held       = mem_req_addr;
            cycles++;
            assert (cycles < HIT_LIMIT) else
                report_failure("stall_reorder: requests not accepted");
            step();
            read_addr = '0;
            #1;
        end
        // tags went out as 1, 2, 3
        for (int t = 3; t > 0; t--) begin
            step();
            resp_tag = mem_tag_t'(t);
        end
        step();
        resp_tag     = '0;
        stall_cycles = 0;
        for (int k = 0; k < 3; k++) begin
            step();
            drive_load(0, blocks[k]);
            serve_until_hit("stall_reorder", 0, blocks[k]);
        end
        check_value("stall_reorder requests", 3, accept_count);
    endtask

    task automatic test_capacity_eviction();
        int hits;
        apply_reset();
        pick_blocks(9);
        for (int k = 0; k < 9; k++) begin
            step();
            drive_load(0, blocks[k]);
            serve_until_hit("capacity_eviction fill", 0, blocks[k]);
            if (k == 7) begin
                for (int j = 0; j < 8; j++) begin
                    step();
                    check_hit("capacity_eviction full", 0, blocks[j]);
                end
            end
        end
        hits = 0;
        for (int j = 0; j < 8; j++) begin
            step();
            drive_load(0, blocks[j]);
            #1;
            if (cache_out[0].valid) begin
                hits++;
                check_value("capacity_eviction survivor data", expected_block(blocks[j]),
                            cache_out[0].data);
            end
        end
        check_value("capacity_eviction survivors", 7, hits);
        step();
        check_hit("capacity_eviction ninth", 0, blocks[8]);
    endtask

    task automatic test_mshr_limit();
        apply_reset();
        pick_blocks(6);
        for (int k = 0; k < 6; k += 2) begin
            drive_load(0, blocks[k]);
            drive_load(1, blocks[k + 1]);
            step();
        end
        read_addr = '0;
        // memory stays silent here
        repeat (20) begin
            step();
            assert (accept_count <= MSHR_ENTRIES) else
                report_failure("mshr_limit: more requests accepted than MSHR entries");
        end
        for (int k = 0; k < 6; k++) begin
            step();
            read_addr = '0;
            drive_load(0, blocks[k]);
            serve_until_hit("mshr_limit fill", 0, blocks[k]);
        end
        for (int k = 0; k < 6; k++) begin
            step();
            check_hit("mshr_limit final", 0, blocks[k]);
        end
    endtask

    initial begin
        seed         = 32'hb16fc9dd;
        error_count  = 0;
        rst          = 1'b1;
        read_addr    = '0;
        stall_cycles = 0;
        resp_tag     = '0;
        test_reset_state();
        test_miss_then_hit();
        test_merge();
        test_stall_reorder();
        test_capacity_eviction();
        test_mshr_limit();
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
logic/dcache_pkg.sv
logic/cache_mshr_if.sv
logic/lfsr.sv
logic/dcache.sv
logic/dcache_mshr.sv
logic/dcache_subsystem.sv
verification/mem_responder.sv
verification/dcache_subsystem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module dcache_subsystem_tb -o dcache_subsystem_tb_sim

./obj_dir/dcache_subsystem_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1
